// ==== router_cfg.svh ====
`ifndef ROUTER_CFG_SVH
`define ROUTER_CFG_SVH

// header lines held by the inspector
// padded ethernet, ipv4, udp, sequence and vrt header
`define HDR_LINES 13
// first header line sent to the dsp output
`define DSP_OFFSET 11

// cpu capture buffer of 512 lines
`define CPU_BUF_AW 9

// setting bus register addresses
`define SET_ADDR_IP 1
`define SET_ADDR_PORTS 2
`define SET_ADDR_CPU_CTRL 3

// protocol field values
`define ETH_TYPE_IPV4 16'h0800
`define IPV4_PROTO_UDP 8'h11

`endif

// ==== stream_pkg.sv ====
package stream_pkg;

    // flag nibble carried on every stream line
    typedef logic [3:0]  line_flags_t;
    typedef logic [31:0] line_data_t;

    localparam int FLAG_SOF = 0;
    localparam int FLAG_EOF = 1;

    // flags of a line that opens a frame
    localparam line_flags_t FLAGS_SOF = 4'b0001;

    typedef struct packed {
        line_flags_t flags;
        line_data_t  data;
    } stream_line_t;

    // where the inspector sends a frame
    typedef enum logic [1:0] {
        DEST_DSP,
        DEST_EXT,
        DEST_CPU
    } insp_dest_t;

endpackage

// ==== ctrl_pkg.sv ====
`include "router_cfg.svh"

package ctrl_pkg;

    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;

    // setting bus fields
    typedef logic [7:0]  set_addr_t;
    typedef logic [31:0] set_data_t;

    typedef struct packed {
        ip_addr_t  my_ip;
        udp_port_t dsp_udp_port;
        logic      cpu_out_hs_ctrl;
    } router_cfg_t;

    typedef logic [`CPU_BUF_AW-1:0] line_count_t;

    // status word read by the host
    typedef struct packed {
        logic [15-`CPU_BUF_AW:0] rsvd_hi;
        line_count_t             line_count;
        logic [14:0]             rsvd_lo;
        logic                    cpu_out_hs_stat;
    } router_status_t;

    typedef enum logic [1:0] {READ_PRE, READ_HDR, WRITE_REGS, WRITE_LIVE} insp_state_t;

    typedef enum logic [1:0] {WAIT_SOF, WAIT_EOF, WAIT_CTRL_HI, WAIT_CTRL_LO} cap_state_t;

endpackage

// ==== router_settings.sv ====
`timescale 1ns/1ns
`include "router_cfg.svh"

module router_settings import ctrl_pkg::*; (
    input  logic        stream_clk,
    input  logic        arst_n_i,
    input  logic        set_stb_i,
    input  set_addr_t   set_addr_i,
    input  set_data_t   set_data_i,
    output router_cfg_t cfg_o
);

    ip_addr_t  my_ip_q;
    udp_port_t dsp_port_q;
    logic      hs_ctrl_q;

    logic wr_ip;
    logic wr_ports;
    logic wr_cpu_ctrl;

    // address decode
    assign wr_ip       = set_stb_i && (set_addr_i == set_addr_t'(`SET_ADDR_IP));
    assign wr_ports    = set_stb_i && (set_addr_i == set_addr_t'(`SET_ADDR_PORTS));
    assign wr_cpu_ctrl = set_stb_i && (set_addr_i == set_addr_t'(`SET_ADDR_CPU_CTRL));

    always_ff @(posedge stream_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            my_ip_q    <= '0;
            dsp_port_q <= '0;
            hs_ctrl_q  <= 1'b0;
        end else begin
            if (wr_ip) begin
                my_ip_q <= set_data_i;
            end
            // low half holds the dsp port
            if (wr_ports) begin
                dsp_port_q <= set_data_i[15:0];
            end
            // host toggles bit 0 to release a captured frame
            if (wr_cpu_ctrl) begin
                hs_ctrl_q <= set_data_i[0];
            end
        end
    end

    assign cfg_o = '{
        my_ip:           my_ip_q,
        dsp_udp_port:    dsp_port_q,
        cpu_out_hs_ctrl: hs_ctrl_q
    };

endmodule

// ==== com_inspector.sv ====
`timescale 1ns/1ns
`include "router_cfg.svh"

module com_inspector import stream_pkg::*, ctrl_pkg::*; (
    input  logic         stream_clk,
    input  logic         arst_n_i,
    input  router_cfg_t  cfg_i,
    input  stream_line_t in_line_i,
    input  logic         in_valid_i,
    output logic         in_ready_o,
    output stream_line_t dsp_line_o,
    output logic         dsp_valid_o,
    input  logic         dsp_ready_i,
    output stream_line_t ext_line_o,
    output logic         ext_valid_o,
    input  logic         ext_ready_i,
    output stream_line_t cpu_line_o,
    output logic         cpu_valid_o,
    input  logic         cpu_ready_i
);

    localparam int IDX_W = $clog2(`HDR_LINES);
    typedef logic [IDX_W-1:0] hdr_idx_t;

    localparam hdr_idx_t LAST_IDX = hdr_idx_t'(`HDR_LINES - 1);
    localparam hdr_idx_t DSP_IDX  = hdr_idx_t'(`DSP_OFFSET);

    insp_state_t  state_q;
    insp_dest_t   dest_q;
    hdr_idx_t     idx_q;
    stream_line_t hdr_q [`HDR_LINES];

    logic [47:0] eth_dst_mac;
    logic [15:0] eth_type;
    logic [7:0]  ipv4_proto;
    ip_addr_t    ipv4_dst;
    udp_port_t   udp_dst_port;
    logic [15:0] vrt_size;

    logic         in_fire;
    logic         hdr_wr;
    logic         hdr_end;
    insp_dest_t   next_dest;
    stream_line_t out_line;
    logic         out_valid;
    logic         out_ready;
    logic         out_fire;

    ////////////////////////////////////////////////////////////////////////////
    // header capture and routing decision
    ////////////////////////////////////////////////////////////////////////////

    // field positions in the padded ethernet/ipv4/udp header
    assign eth_dst_mac  = {hdr_q[0].data[15:0], hdr_q[1].data};
    assign eth_type     = hdr_q[3].data[15:0];
    assign ipv4_proto   = hdr_q[6].data[23:16];
    assign ipv4_dst     = hdr_q[8].data;
    assign udp_dst_port = hdr_q[9].data[15:0];
    // vrt size sits on the line that closes the header
    assign vrt_size     = in_line_i.data[15:0];

    assign in_fire = in_valid_i && in_ready_o;
    // lines ahead of a start of frame are dropped
    assign hdr_wr  = in_fire && ((state_q == READ_HDR) || in_line_i.flags[FLAG_SOF]);
    assign hdr_end = (idx_q == LAST_IDX) || in_line_i.flags[FLAG_EOF];

    always_comb begin
        if (in_line_i.flags[FLAG_EOF] || (eth_dst_mac == {48{1'b1}}) ||
            (eth_type != `ETH_TYPE_IPV4) || (ipv4_proto != `IPV4_PROTO_UDP)) begin
            next_dest = DEST_CPU;
        end else if (ipv4_dst != cfg_i.my_ip) begin
            next_dest = DEST_EXT;
        end else if ((udp_dst_port == cfg_i.dsp_udp_port) && (vrt_size != 16'h0)) begin
            next_dest = DEST_DSP;
        end else begin
            next_dest = DEST_CPU;
        end
    end

    always_ff @(posedge stream_clk) begin
        if (hdr_wr) begin
            hdr_q[idx_q] <= in_line_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // output side
    ////////////////////////////////////////////////////////////////////////////

    // replay from the header registers then pass the input through
    always_comb begin
        if (state_q == WRITE_REGS) begin
            out_line = hdr_q[idx_q];
            // dsp frames start at the sequence line
            if ((dest_q == DEST_DSP) && (idx_q == DSP_IDX)) begin
                out_line.flags = FLAGS_SOF;
            end
        end else begin
            out_line = in_line_i;
        end
    end

    assign out_valid = (state_q == WRITE_REGS) || ((state_q == WRITE_LIVE) && in_valid_i);

    always_comb begin
        case (dest_q)
            DEST_DSP: out_ready = dsp_ready_i;
            DEST_EXT: out_ready = ext_ready_i;
            default:  out_ready = cpu_ready_i;
        endcase
    end

    assign out_fire = out_valid && out_ready;

    assign dsp_line_o  = out_line;
    assign ext_line_o  = out_line;
    assign cpu_line_o  = out_line;
    assign dsp_valid_o = out_valid && (dest_q == DEST_DSP);
    assign ext_valid_o = out_valid && (dest_q == DEST_EXT);
    assign cpu_valid_o = out_valid && (dest_q == DEST_CPU);

    always_comb begin
        case (state_q)
            READ_PRE, READ_HDR: in_ready_o = 1'b1;
            WRITE_LIVE:         in_ready_o = out_ready;
            default:            in_ready_o = 1'b0;
        endcase
    end

    always_ff @(posedge stream_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= READ_PRE;
            dest_q  <= DEST_CPU;
            idx_q   <= '0;
        end else begin
            case (state_q)
                READ_PRE, READ_HDR: begin
                    if (hdr_wr) begin
                        if (hdr_end) begin
                            state_q <= WRITE_REGS;
                            dest_q  <= next_dest;
                            idx_q   <= (next_dest == DEST_DSP) ? DSP_IDX : '0;
                        end else begin
                            state_q <= READ_HDR;
                            idx_q   <= idx_q + hdr_idx_t'(1);
                        end
                    end
                end
                WRITE_REGS: begin
                    if (out_fire) begin
                        if (out_line.flags[FLAG_EOF]) begin
                            state_q <= READ_PRE;
                            idx_q   <= '0;
                        end else if (idx_q == LAST_IDX) begin
                            state_q <= WRITE_LIVE;
                            idx_q   <= '0;
                        end else begin
                            idx_q <= idx_q + hdr_idx_t'(1);
                        end
                    end
                end
                WRITE_LIVE: begin
                    if (out_fire && in_line_i.flags[FLAG_EOF]) begin
                        state_q <= READ_PRE;
                    end
                end
            endcase
        end
    end

endmodule

// ==== cpu_out_capture.sv ====
`timescale 1ns/1ns
`include "router_cfg.svh"

module cpu_out_capture import stream_pkg::*, ctrl_pkg::*; (
    input  logic                   stream_clk,
    input  logic                   arst_n_i,
    input  router_cfg_t            cfg_i,
    input  stream_line_t           line_i,
    input  logic                   valid_i,
    output logic                   ready_o,
    input  logic [`CPU_BUF_AW-1:0] rd_addr_i,
    output line_data_t             rd_data_o,
    output router_status_t         status_o
);

    cap_state_t  state_q;
    line_count_t wr_addr_q;
    line_data_t  buf_mem [2**`CPU_BUF_AW];
    logic        wr_fire;

    assign ready_o = (state_q == WAIT_SOF) || (state_q == WAIT_EOF);
    assign wr_fire = ready_o && valid_i;

    ////////////////////////////////////////////////////////////////////////////
    // line buffer
    ////////////////////////////////////////////////////////////////////////////

    // stray lines before a start of frame sit at address 0 until overwritten
    always_ff @(posedge stream_clk) begin
        if (wr_fire) begin
            buf_mem[wr_addr_q] <= line_i.data;
        end
    end

    // host read port
    always_ff @(posedge stream_clk) begin
        rd_data_o <= buf_mem[rd_addr_i];
    end

    ////////////////////////////////////////////////////////////////////////////
    // capture and host handshake
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge stream_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= WAIT_SOF;
            wr_addr_q <= '0;
        end else begin
            case (state_q)
                WAIT_SOF: begin
                    if (wr_fire && line_i.flags[FLAG_SOF]) begin
                        wr_addr_q <= wr_addr_q + line_count_t'(1);
                        state_q   <= line_i.flags[FLAG_EOF] ? WAIT_CTRL_HI : WAIT_EOF;
                    end
                end
                WAIT_EOF: begin
                    if (wr_fire) begin
                        wr_addr_q <= wr_addr_q + line_count_t'(1);
                        if (line_i.flags[FLAG_EOF]) begin
                            state_q <= WAIT_CTRL_HI;
                        end
                    end
                end
                WAIT_CTRL_HI: begin
                    if (cfg_i.cpu_out_hs_ctrl) begin
                        state_q <= WAIT_CTRL_LO;
                    end
                end
                WAIT_CTRL_LO: begin
                    // host has the frame so the count goes back to zero
                    wr_addr_q <= '0;
                    if (!cfg_i.cpu_out_hs_ctrl) begin
                        state_q <= WAIT_SOF;
                    end
                end
            endcase
        end
    end

    assign status_o = '{
        rsvd_hi:         '0,
        line_count:      wr_addr_q,
        rsvd_lo:         '0,
        cpu_out_hs_stat: (state_q == WAIT_CTRL_HI)
    };

endmodule

// ==== packet_router.sv ====
`timescale 1ns/1ns
`include "router_cfg.svh"

module packet_router import stream_pkg::*, ctrl_pkg::*; (
    input  logic                   stream_clk,
    input  logic                   arst_n_i,
    // setting bus
    input  logic                   set_stb_i,
    input  set_addr_t              set_addr_i,
    input  set_data_t              set_data_i,
    // communication input
    input  stream_line_t           com_line_i,
    input  logic                   com_valid_i,
    output logic                   com_ready_o,
    // fast path and external outputs
    output stream_line_t           dsp_out_line_o,
    output logic                   dsp_out_valid_o,
    input  logic                   dsp_out_ready_i,
    output stream_line_t           ext_out_line_o,
    output logic                   ext_out_valid_o,
    input  logic                   ext_out_ready_i,
    // host access to the capture buffer
    input  logic [`CPU_BUF_AW-1:0] cpu_rd_addr_i,
    output line_data_t             cpu_rd_data_o,
    output router_status_t         status_o
);

    router_cfg_t  cfg;
    stream_line_t cpu_line;
    logic         cpu_valid;
    logic         cpu_ready;

    ////////////////////////////////////////////////////////////////////////////
    // configuration, inspection and capture
    ////////////////////////////////////////////////////////////////////////////

    router_settings settings0 (
        .stream_clk (stream_clk),
        .arst_n_i   (arst_n_i),
        .set_stb_i  (set_stb_i),
        .set_addr_i (set_addr_i),
        .set_data_i (set_data_i),
        .cfg_o      (cfg)
    );

    com_inspector insp0 (
        .stream_clk  (stream_clk),
        .arst_n_i    (arst_n_i),
        .cfg_i       (cfg),
        .in_line_i   (com_line_i),
        .in_valid_i  (com_valid_i),
        .in_ready_o  (com_ready_o),
        .dsp_line_o  (dsp_out_line_o),
        .dsp_valid_o (dsp_out_valid_o),
        .dsp_ready_i (dsp_out_ready_i),
        .ext_line_o  (ext_out_line_o),
        .ext_valid_o (ext_out_valid_o),
        .ext_ready_i (ext_out_ready_i),
        .cpu_line_o  (cpu_line),
        .cpu_valid_o (cpu_valid),
        .cpu_ready_i (cpu_ready)
    );

    cpu_out_capture capture0 (
        .stream_clk (stream_clk),
        .arst_n_i   (arst_n_i),
        .cfg_i      (cfg),
        .line_i     (cpu_line),
        .valid_i    (cpu_valid),
        .ready_o    (cpu_ready),
        .rd_addr_i  (cpu_rd_addr_i),
        .rd_data_o  (cpu_rd_data_o),
        .status_o   (status_o)
    );

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock (
    output logic clk_o,
    output logic arst_n_o
);

    // 4 ns period
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // reset held for the first three cycles
    initial begin
        arst_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule

// ==== packet_router_chk.sv ====
`timescale 1ns/1ns

module packet_router_chk import stream_pkg::*, ctrl_pkg::*; (
    input logic           clk_i,
    input logic           arst_n_i,
    input stream_line_t   dsp_line_i,
    input logic           dsp_valid_i,
    input logic           dsp_ready_i,
    input stream_line_t   ext_line_i,
    input logic           ext_valid_i,
    input logic           ext_ready_i,
    input logic           cap_ready_i,
    input router_status_t status_i
);

    // an offered line stays put until the sink takes it
    dsp_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (dsp_valid_i && !dsp_ready_i) |=> (dsp_valid_i && $stable(dsp_line_i)))
        else $error("dsp_out valid or line changed before acceptance");

    ext_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (ext_valid_i && !ext_ready_i) |=> (ext_valid_i && $stable(ext_line_i)))
        else $error("ext_out valid or line changed before acceptance");

    reset_quiet: assert property (@(posedge clk_i)
        !arst_n_i |-> (!dsp_valid_i && !ext_valid_i))
        else $error("output valid high during reset");

    // a frame waiting for the host blocks further capture
    cap_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(status_i.cpu_out_hs_stat && cap_ready_i))
        else $error("capture ready high while handshake status is set");

endmodule

// ==== packet_router_tb.sv ====
`timescale 1ns/1ns
`include "router_cfg.svh"

module packet_router_tb import stream_pkg::*, ctrl_pkg::*; ();

    localparam int          TMO        = 4000;
    localparam ip_addr_t    MY_IP      = 32'hc0a8_0a02;
    localparam ip_addr_t    OTHER_IP   = 32'hc0a8_0a63;
    localparam udp_port_t   DSP_PORT   = 16'd49200;
    localparam udp_port_t   OTHER_PORT = 16'd5000;
    localparam logic [47:0] HOST_MAC   = 48'h0050_c2a1_b2c3;

    logic                   stream_clk;
    logic                   arst_n;
    logic                   set_stb;
    set_addr_t              set_addr;
    set_data_t              set_data;
    stream_line_t           com_line;
    logic                   com_valid;
    logic                   com_ready;
    stream_line_t           dsp_line;
    logic                   dsp_valid;
    logic                   dsp_ready = 1'b1;
    stream_line_t           ext_line;
    logic                   ext_valid;
    logic                   ext_ready = 1'b1;
    logic [`CPU_BUF_AW-1:0] cpu_rd_addr;
    line_data_t             cpu_rd_data;
    router_status_t         status;

    logic         rand_ready = 1'b0;
    stream_line_t tx_q[$];
    stream_line_t dsp_rx[$];
    stream_line_t ext_rx[$];
    int           errors;
    int           err_mark;
    int           tests_run;
    int           tests_failed;

    tb_clock clk0 (
        .clk_o    (stream_clk),
        .arst_n_o (arst_n)
    );

    packet_router dut0 (
        .stream_clk      (stream_clk),
        .arst_n_i        (arst_n),
        .set_stb_i       (set_stb),
        .set_addr_i      (set_addr),
        .set_data_i      (set_data),
        .com_line_i      (com_line),
        .com_valid_i     (com_valid),
        .com_ready_o     (com_ready),
        .dsp_out_line_o  (dsp_line),
        .dsp_out_valid_o (dsp_valid),
        .dsp_out_ready_i (dsp_ready),
        .ext_out_line_o  (ext_line),
        .ext_out_valid_o (ext_valid),
        .ext_out_ready_i (ext_ready),
        .cpu_rd_addr_i   (cpu_rd_addr),
        .cpu_rd_data_o   (cpu_rd_data),
        .status_o        (status)
    );

    bind packet_router packet_router_chk chk0 (
        .clk_i       (stream_clk),
        .arst_n_i    (arst_n_i),
        .dsp_line_i  (dsp_out_line_o),
        .dsp_valid_i (dsp_out_valid_o),
        .dsp_ready_i (dsp_out_ready_i),
        .ext_line_i  (ext_out_line_o),
        .ext_valid_i (ext_out_valid_o),
        .ext_ready_i (ext_out_ready_i),
        .cap_ready_i (cpu_ready),
        .status_i    (status_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // output monitors and dsp back-pressure
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge stream_clk) begin
        if (dsp_valid && dsp_ready) begin
            dsp_rx.push_back(dsp_line);
        end
        if (ext_valid && ext_ready) begin
            ext_rx.push_back(ext_line);
        end
    end

    // ready high about two cycles in three while enabled
    always @(posedge stream_clk) begin
        if (rand_ready) begin
            dsp_ready <= (($urandom % 3) != 0);
            ext_ready <= (($urandom % 3) != 0);
        end else begin
            dsp_ready <= 1'b1;
            ext_ready <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // frame model
    ////////////////////////////////////////////////////////////////////////////

    function automatic insp_dest_t expected_dest(input logic [47:0] mac,
            input logic [15:0] etype, input logic [7:0] proto, input ip_addr_t ip,
            input udp_port_t port, input logic [15:0] vrt, input int nlines);
        // a frame that ends inside the header has no usable fields
        if ((nlines <= `HDR_LINES) || (mac == 48'hffff_ffff_ffff) ||
                (etype != `ETH_TYPE_IPV4) || (proto != `IPV4_PROTO_UDP)) begin
            return DEST_CPU;
        end
        if (ip != MY_IP) begin
            return DEST_EXT;
        end
        if ((port == DSP_PORT) && (vrt != 16'h0)) begin
            return DEST_DSP;
        end
        return DEST_CPU;
    endfunction

    task automatic build_frame(input logic [47:0] mac, input logic [15:0] etype,
            input logic [7:0] proto, input ip_addr_t ip, input udp_port_t port,
            input logic [15:0] vrt, input int nlines, output insp_dest_t dest);
        stream_line_t l;
        tx_q.delete();
        for (int i = 0; i < nlines; i++) begin
            l.flags = '0;
            l.data  = $urandom;
            case (i)
                0:              l.data[15:0]  = mac[47:32];
                1:              l.data        = mac[31:0];
                3:              l.data[15:0]  = etype;
                6:              l.data[23:16] = proto;
                8:              l.data        = ip;
                9:              l.data[15:0]  = port;
                `HDR_LINES - 1: l.data[15:0]  = vrt;
                default:        ;
            endcase
            l.flags[FLAG_SOF] = (i == 0);
            l.flags[FLAG_EOF] = (i == nlines - 1);
            tx_q.push_back(l);
        end
        dest = expected_dest(mac, etype, proto, ip, port, vrt, nlines);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // bus helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic write_setting(input int addr, input set_data_t data);
        set_stb  <= 1'b1;
        set_addr <= set_addr_t'(addr);
        set_data <= data;
        @(posedge stream_clk);
        set_stb  <= 1'b0;
    endtask

    task automatic read_buf(input int addr, output line_data_t word);
        cpu_rd_addr <= line_count_t'(addr);
        @(posedge stream_clk);
        @(posedge stream_clk);
        word = cpu_rd_data;
    endtask

    task automatic send_frame();
        int t;
        foreach (tx_q[i]) begin
            com_line  <= tx_q[i];
            com_valid <= 1'b1;
            t = 0;
            @(posedge stream_clk);
            while (!com_ready && (t < TMO)) begin
                @(posedge stream_clk);
                t++;
            end
            if (!com_ready) begin
                $display("com input never accepted line %0d", i);
                errors++;
                break;
            end
        end
        com_valid <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // response checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_stream_out(input insp_dest_t dest);
        stream_line_t exp_q[$];
        stream_line_t got_q[$];
        int           t;
        if (dest == DEST_DSP) begin
            for (int i = `DSP_OFFSET; i < tx_q.size(); i++) begin
                exp_q.push_back(tx_q[i]);
            end
            exp_q[0].flags = 4'b0001;
        end else begin
            exp_q = tx_q;
        end
        t = 0;
        while ((((dest == DEST_DSP) ? dsp_rx.size() : ext_rx.size()) < exp_q.size()) &&
                (t < TMO)) begin
            @(posedge stream_clk);
            t++;
        end
        if (dest == DEST_DSP) begin
            got_q = dsp_rx;
        end else begin
            got_q = ext_rx;
        end
        if (got_q.size() != exp_q.size()) begin
            $display("output delivered %0d lines instead of %0d", got_q.size(), exp_q.size());
            errors++;
        end
        for (int i = 0; (i < exp_q.size()) && (i < got_q.size()); i++) begin
            if (got_q[i] !== exp_q[i]) begin
                $display("[ERROR] %s line %0d: expected %h, got %h",
                         (dest == DEST_DSP) ? "dsp_out_line_o" : "ext_out_line_o",
                         i, exp_q[i], got_q[i]);
                errors++;
            end
        end
        if (((dest == DEST_DSP) ? ext_rx.size() : dsp_rx.size()) != 0) begin
            $display("lines appeared on the wrong output");
            errors++;
        end
    endtask

    task automatic await_capture();
        logic [31:0] exp_status;
        line_data_t  word;
        int          t;
        t = 0;
        while (!status.cpu_out_hs_stat && (t < TMO)) begin
            @(posedge stream_clk);
            t++;
        end
        if (!status.cpu_out_hs_stat) begin
            $display("capture buffer never reported a complete frame");
            errors++;
        end else begin
            // line count from bit 16 up and handshake status in bit 0
            exp_status = (32'(tx_q.size()) << 16) | 32'h1;
            if (32'(status) !== exp_status) begin
                $display("[ERROR] status_o: expected %h, got %h", exp_status, status);
                errors++;
            end
            foreach (tx_q[i]) begin
                read_buf(i, word);
                if (word !== tx_q[i].data) begin
                    $display("[ERROR] cpu_rd_data_o at %h: expected %h, got %h",
                             i, tx_q[i].data, word);
                    errors++;
                end
            end
        end
    endtask

    task automatic release_capture();
        int t;
        write_setting(`SET_ADDR_CPU_CTRL, 32'h1);
        write_setting(`SET_ADDR_CPU_CTRL, 32'h0);
        t = 0;
        while ((32'(status) != 32'h0) && (t < TMO)) begin
            @(posedge stream_clk);
            t++;
        end
        if (32'(status) != 32'h0) begin
            $display("capture status did not clear after the host handshake");
            errors++;
        end
    endtask

    task automatic run_frame(input insp_dest_t dest);
        dsp_rx.delete();
        ext_rx.delete();
        send_frame();
        if (dest == DEST_CPU) begin
            await_capture();
            release_capture();
            if ((dsp_rx.size() != 0) || (ext_rx.size() != 0)) begin
                $display("a frame for the cpu also left on a stream output");
                errors++;
            end
        end else begin
            check_stream_out(dest);
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - err_mark);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic dsp_fast_path();
        insp_dest_t dest;
        err_mark = errors;
        build_frame(HOST_MAC, `ETH_TYPE_IPV4, `IPV4_PROTO_UDP, MY_IP, DSP_PORT,
                    16'h0020, 24, dest);
        run_frame(dest);
        report_test("dsp fast path");
    endtask

    task automatic ext_forward();
        insp_dest_t dest;
        err_mark = errors;
        build_frame(HOST_MAC, `ETH_TYPE_IPV4, `IPV4_PROTO_UDP, OTHER_IP, DSP_PORT,
                    16'h0020, 18, dest);
        run_frame(dest);
        report_test("external forward");
    endtask

    task automatic cpu_capture();
        insp_dest_t dest;
        err_mark = errors;
        build_frame(HOST_MAC, `ETH_TYPE_IPV4, `IPV4_PROTO_UDP, MY_IP, OTHER_PORT,
                    16'h0020, 16, dest);
        run_frame(dest);
        report_test("cpu capture");
    endtask

    task automatic cpu_fallback_classes();
        insp_dest_t dest;
        err_mark = errors;
        build_frame(48'hffff_ffff_ffff, `ETH_TYPE_IPV4, `IPV4_PROTO_UDP, MY_IP, DSP_PORT,
                    16'h0020, 20, dest);
        run_frame(dest);
        // ipv6 ethertype
        build_frame(HOST_MAC, 16'h86dd, `IPV4_PROTO_UDP, MY_IP, DSP_PORT,
                    16'h0020, 20, dest);
        run_frame(dest);
        build_frame(HOST_MAC, `ETH_TYPE_IPV4, `IPV4_PROTO_UDP, MY_IP, DSP_PORT,
                    16'h0020, 9, dest);
        run_frame(dest);
        report_test("cpu fallback classes");
    endtask

    task automatic backpressure_and_hold();
        insp_dest_t dest;
        logic       sent;
        int         a_lines;
        err_mark = errors;
        rand_ready <= 1'b1;
        build_frame(HOST_MAC, `ETH_TYPE_IPV4, `IPV4_PROTO_UDP, MY_IP, DSP_PORT,
                    16'h0100, 80, dest);
        run_frame(dest);
        // external frame under the same random back-pressure
        build_frame(HOST_MAC, `ETH_TYPE_IPV4, `IPV4_PROTO_UDP, OTHER_IP, OTHER_PORT,
                    16'h0, 40, dest);
        run_frame(dest);
        rand_ready <= 1'b0;
        // first cpu frame stays captured while the second one is offered
        build_frame(HOST_MAC, `ETH_TYPE_IPV4, `IPV4_PROTO_UDP, MY_IP, OTHER_PORT,
                    16'h0, 20, dest);
        a_lines = tx_q.size();
        send_frame();
        await_capture();
        build_frame(HOST_MAC, `ETH_TYPE_IPV4, `IPV4_PROTO_UDP, MY_IP, OTHER_PORT,
                    16'h0, 25, dest);
        sent = 1'b0;
        fork
            begin
                send_frame();
                sent = 1'b1;
            end
            begin
                repeat (50) @(posedge stream_clk);
                if (sent) begin
                    $display("second cpu frame went through before the handshake");
                    errors++;
                end
                if (status.line_count != line_count_t'(a_lines)) begin
                    $display("[ERROR] status_o line count: expected %h, got %h",
                             line_count_t'(a_lines), status.line_count);
                    errors++;
                end
                release_capture();
            end
        join
        await_capture();
        release_capture();
        report_test("back-pressure and hold");
    endtask

    initial begin
        int t;
        void'($urandom(35));
        set_stb      = 1'b0;
        set_addr     = '0;
        set_data     = '0;
        com_line     = '0;
        com_valid    = 1'b0;
        cpu_rd_addr  = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        t = 0;
        while (!arst_n && (t < 50)) begin
            @(posedge stream_clk);
            t++;
        end
        if (!arst_n) begin
            $display("reset was never released");
            errors++;
        end
        @(posedge stream_clk);
        write_setting(`SET_ADDR_IP, MY_IP);
        // upper half is the second dsp port, which the router ignores
        write_setting(`SET_ADDR_PORTS, {16'hbeef, DSP_PORT});
        @(posedge stream_clk);

        dsp_fast_path();
        ext_forward();
        cpu_capture();
        cpu_fallback_classes();
        backpressure_and_hold();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+.
stream_pkg.sv
ctrl_pkg.sv
router_settings.sv
com_inspector.sv
cpu_out_capture.sv
packet_router.sv
tb_clock.sv
packet_router_chk.sv
packet_router_tb.sv

// ==== Makefile ====
SIM  := obj_dir/Vpacket_router_tb
SRCS := $(filter-out +%,$(shell cat all.f)) router_cfg.svh

.PHONY: all run clean

all: run

$(SIM): $(SRCS) all.f
	verilator --binary --timing --assert -j 0 --top-module packet_router_tb -f all.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^Finished with no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
